//--- common/backend_pkg.sv
package backend_pkg;

    localparam int WORD_W = 16;
    localparam int REG_N  = 4;
    localparam int IMM_W  = 8;

    typedef logic [WORD_W-1:0]        word_t;
    typedef logic [$clog2(REG_N)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR,
        LHI, ADI, LWD, SWD, WWD, HLT
    } op_t;

    // Decoded instruction as handed over by the front end
    typedef struct packed {
        logic             valid;
        op_t              op;
        reg_idx_t         rs;
        reg_idx_t         rt;
        reg_idx_t         rd;
        logic [IMM_W-1:0] imm;
    } issue_t;

    typedef struct packed {
        word_t    alu_result; // ALU value or effective address
        word_t    r_data1;    // Forwarded rs
        word_t    r_data2;    // Forwarded rt, store data
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     is_wwd;
        logic     is_done;
    } ex_mem_t;

    typedef struct packed {
        word_t    wb_data;
        word_t    wwd_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     is_wwd;
        logic     is_done;
    } mem_wb_t;

endpackage

//--- hw/reg_file.sv
module reg_file
    import backend_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);

    word_t regs [REG_N];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-first: a read of the register being written sees the new value
    always_comb begin
        rs_data = (wr_en && wr_idx == rs) ? wr_data : regs[rs];
        rt_data = (wr_en && wr_idx == rt) ? wr_data : regs[rt];
    end

endmodule

//--- hw/exec_unit.sv
module exec_unit
    import backend_pkg::*;
(
    input  issue_t   issue,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  logic     fwd_en,
    input  reg_idx_t fwd_idx,
    input  word_t    fwd_data,
    output ex_mem_t  ex_next
);

    word_t op_a;
    word_t op_b;
    word_t imm_sext;
    word_t imm_hi;
    word_t result;

    // Memory-stage result overrides a stale register read
    assign op_a = (fwd_en && fwd_idx == issue.rs) ? fwd_data : rs_data;
    assign op_b = (fwd_en && fwd_idx == issue.rt) ? fwd_data : rt_data;

    assign imm_sext = {{(WORD_W - IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
    assign imm_hi   = {issue.imm, {(WORD_W - IMM_W){1'b0}}};

    always_comb begin
        case (issue.op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            ORR:     result = op_a | op_b;
            NOT:     result = ~op_a;
            TCP:     result = ~op_a + 1'b1;
            SHL:     result = {op_a[WORD_W-2:0], 1'b0};
            SHR:     result = {op_a[WORD_W-1], op_a[WORD_W-1:1]}; // Arithmetic
            LHI:     result = imm_hi;
            ADI:     result = op_a + imm_sext;
            LWD,
            SWD:     result = op_a + imm_sext; // Effective address, wraps
            default: result = op_a;
        endcase
    end

    always_comb begin
        ex_next            = '0;
        ex_next.alu_result = result;
        ex_next.r_data1    = op_a;
        ex_next.r_data2    = op_b;
        ex_next.rd         = issue.rd;

        case (issue.op)
            ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR, LHI, ADI: begin
                ex_next.reg_write = 1'b1;
            end
            LWD: begin
                ex_next.mem_read   = 1'b1;
                ex_next.mem_to_reg = 1'b1;
                ex_next.reg_write  = 1'b1;
            end
            SWD: begin
                ex_next.mem_write = 1'b1;
            end
            WWD: begin
                ex_next.is_wwd = 1'b1;
            end
            HLT: begin
                ex_next.is_done = 1'b1;
            end
            default: begin
                ex_next.reg_write = 1'b0; // Unused encodings do nothing
            end
        endcase
    end

endmodule

//--- hw/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Only the valid bit is control state
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid & ~flush; // Flush leaves a bubble
        end
    end

    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

//--- hw/data_mem.sv
module data_mem
    import backend_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  logic              wr_en,
    input  word_t             wr_data,
    output word_t             rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Asynchronous read, a load sees the word in the same cycle
    assign rd_data = mem[addr];

endmodule

//--- hw/cpu_backend.sv
module cpu_backend
    import backend_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic   clk,
    input  logic   reset_n,
    input  issue_t issue,
    input  logic   flush,
    output logic   wwd_valid,
    output word_t  wwd_data,
    output logic   done
);

    word_t   rs_data;
    word_t   rt_data;
    ex_mem_t ex_next;
    ex_mem_t ex_q;
    logic    ex_valid;
    word_t   mem_rd_data;
    word_t   mem_result;
    mem_wb_t wb_next;
    mem_wb_t wb_q;
    logic    wb_valid;

    reg_file u_reg_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rs      (issue.rs),
        .rt      (issue.rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr_en   (wb_valid & wb_q.reg_write),
        .wr_idx  (wb_q.rd),
        .wr_data (wb_q.wb_data)
    );

    exec_unit u_exec_unit (
        .issue    (issue),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .fwd_en   (ex_valid & ex_q.reg_write), // Bubbles never forward
        .fwd_idx  (ex_q.rd),
        .fwd_data (mem_result),
        .ex_next  (ex_next)
    );

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (flush),
        .in_valid  (issue.valid),
        .in_data   (ex_next),
        .out_valid (ex_valid),
        .out_data  (ex_q)
    );

    data_mem #(.ADDR_W(ADDR_W)) u_data_mem (
        .clk     (clk),
        .addr    (ex_q.alu_result[ADDR_W-1:0]),
        .wr_en   (ex_valid & ex_q.mem_write),
        .wr_data (ex_q.r_data2),
        .rd_data (mem_rd_data)
    );

    assign mem_result = ex_q.mem_to_reg ? mem_rd_data : ex_q.alu_result;

    always_comb begin
        wb_next.wb_data   = mem_result;
        wb_next.wwd_data  = ex_q.r_data1;
        wb_next.rd        = ex_q.rd;
        wb_next.reg_write = ex_q.reg_write;
        wb_next.is_wwd    = ex_q.is_wwd;
        wb_next.is_done   = ex_q.is_done;
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk       (clk),
        .reset_n   (reset_n),
        .flush     (1'b0),
        .in_valid  (ex_valid),
        .in_data   (wb_next),
        .out_valid (wb_valid),
        .out_data  (wb_q)
    );

    assign wwd_valid = wb_valid & wb_q.is_wwd;
    assign wwd_data  = wb_q.wwd_data;
    assign done      = wb_valid & wb_q.is_done;

endmodule

//--- test/backend_props.sv
module backend_props
    import backend_pkg::*;
(
    input logic   clk,
    input logic   reset_n,
    input issue_t issue,
    input logic   flush,
    input logic   wwd_valid,
    input logic   done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Nothing can reach writeback in the first two cycles after reset
    quiet_after_reset: assert property (@(posedge clk)
        (!reset_n && ($past(reset_n) || $past(reset_n, 2))) |-> (!wwd_valid && !done))
        else $error("outputs active within two cycles of reset release");

    one_output_kind: assert property (@(posedge clk) disable iff (reset_n)
        !(wwd_valid && done))
        else $error("wwd_valid and done high in the same cycle");

    flushed_issue_silent: assert property (@(posedge clk)
        (!reset_n && $past(flush && issue.valid && !reset_n, 2)) |-> (!wwd_valid && !done))
        else $error("flushed issue produced an output two cycles later");

endmodule

bind cpu_backend backend_props u_backend_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .issue     (issue),
    .flush     (flush),
    .wwd_valid (wwd_valid),
    .done      (done)
);

//--- test/backend_tb.sv
module backend_tb
    import backend_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ALU   = 40; // ALU op and WWD pairs
    localparam int N_DEP   = 30;
    localparam int N_MEM   = 12; // Store, load and WWD groups
    localparam int N_FLUSH = 40;
    // All clock cycles of the run including idle ones
    localparam int RUN_CYCLES = 6 + 4 + 2 * N_ALU + N_DEP + 4 + 3 * N_MEM
                              + N_FLUSH + 4 + 2 * N_MEM + 5;

    typedef struct {
        int    tag;
        logic  is_done;
        word_t data;
    } expect_t;

    logic   clk;
    logic   reset_n;
    issue_t issue;
    logic   flush;
    logic   wwd_valid;
    word_t  wwd_data;
    logic   done;

    logic [31:0] lfsr;
    int          cyc;
    word_t       regs_model [REG_N];
    word_t       mem_model [logic [7:0]];
    logic [7:0]  stored_q [$];
    expect_t     exp_q [$];

    cpu_backend #(.ADDR_W(8)) i_cpu_backend (
        .clk       (clk),
        .reset_n   (reset_n),
        .issue     (issue),
        .flush     (flush),
        .wwd_valid (wwd_valid),
        .wwd_data  (wwd_data),
        .done      (done)
    );

    always #4 clk = ~clk;

    initial begin
        repeat (RUN_CYCLES + 50) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES + 50);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_bits(2));
    endfunction

    function automatic op_t rand_alu_op();
        return op_t'(4'(rand_bits(4) % 10)); // ADD up to ADI
    endfunction

    task automatic report_mismatch(input string what, input word_t exp_v, input word_t act_v);
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, what, exp_v, act_v);
        $display("Test failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_outputs();
        logic  exp_wwd;
        logic  exp_done;
        word_t exp_data;
        exp_wwd  = 1'b0;
        exp_done = 1'b0;
        exp_data = '0;
        if (exp_q.size() > 0 && exp_q[0].tag == cyc) begin
            exp_done = exp_q[0].is_done;
            exp_wwd  = !exp_q[0].is_done;
            exp_data = exp_q[0].data;
            void'(exp_q.pop_front());
        end
        assert (wwd_valid === exp_wwd)
            else report_mismatch("wwd_valid", 16'(exp_wwd), 16'(wwd_valid));
        if (exp_wwd) begin
            assert (wwd_data === exp_data) else report_mismatch("wwd_data", exp_data, wwd_data);
        end
        assert (done === exp_done) else report_mismatch("done", 16'(exp_done), 16'(done));
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    // In-order reference model
    task automatic model_issue(input op_t op, input reg_idx_t rs, input reg_idx_t rt,
                               input reg_idx_t rd, input logic [7:0] imm);
        word_t      a;
        word_t      b;
        word_t      sext;
        logic [7:0] addr;
        a    = regs_model[rs];
        b    = regs_model[rt];
        sext = {{8{imm[7]}}, imm};
        addr = 8'(a + sext);
        case (op)
            ADD: regs_model[rd] = a + b;
            SUB: regs_model[rd] = a - b;
            AND: regs_model[rd] = a & b;
            ORR: regs_model[rd] = a | b;
            NOT: regs_model[rd] = ~a;
            TCP: regs_model[rd] = -a;
            SHL: regs_model[rd] = a << 1;
            SHR: regs_model[rd] = word_t'($signed(a) >>> 1);
            LHI: regs_model[rd] = {imm, 8'h00};
            ADI: regs_model[rd] = a + sext;
            LWD: regs_model[rd] = mem_model[addr];
            SWD: begin
                if (!mem_model.exists(addr)) stored_q.push_back(addr);
                mem_model[addr] = b;
            end
            WWD: exp_q.push_back(expect_t'{cyc + 2, 1'b0, a});
            HLT: exp_q.push_back(expect_t'{cyc + 2, 1'b1, 16'h0000});
            default: ;
        endcase
    endtask

    task automatic issue_instr(input op_t op, input reg_idx_t rs, input reg_idx_t rt,
                               input reg_idx_t rd, input logic [7:0] imm, input logic kill);
        next_cycle();
        issue.valid = 1'b1;
        issue.op    = op;
        issue.rs    = rs;
        issue.rt    = rt;
        issue.rd    = rd;
        issue.imm   = imm;
        flush       = kill;
        if (!kill) model_issue(op, rs, rt, rd, imm); // Flushed issue leaves no trace
    endtask

    task automatic idle_cycle();
        next_cycle();
        issue = '0;
        flush = 1'b0;
    endtask

    task automatic wwd(input reg_idx_t r);
        issue_instr(WWD, r, 2'd0, 2'd0, 8'h00, 1'b0);
    endtask

    initial begin
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        reg_idx_t   prev1;
        reg_idx_t   prev2;
        logic [7:0] imm;
        logic [7:0] addr;
        logic       kill;
        clk         = 1'b0;
        reset_n     = 1'b1;
        issue       = '0;
        issue.valid = 1'b1; // A WWD held during reset must be dropped
        issue.op    = WWD;
        flush       = 1'b0;
        lfsr        = 32'h0f1f145e;
        cyc         = 0;
        foreach (regs_model[r]) regs_model[r] = '0;
        repeat (2) @(posedge clk);
        next_cycle();
        reset_n = 1'b0;
        issue   = '0;
        repeat (3) idle_cycle();

        for (int r = 0; r < REG_N; r++) wwd(reg_idx_t'(r)); // Cleared by reset

        for (int i = 0; i < N_ALU; i++) begin
            rd = rand_reg();
            issue_instr(op_t'(4'(i % 10)), rand_reg(), rand_reg(), rd, 8'(rand_bits(8)), 1'b0);
            wwd(rd);
        end

        // Dependent chain with sources one or two instructions back
        prev1 = 2'd0;
        prev2 = 2'd1;
        for (int i = 0; i < N_DEP; i++) begin
            rs = rand_bits(1) ? prev1 : prev2;
            rt = rand_bits(1) ? prev2 : prev1;
            rd = rand_reg();
            issue_instr(rand_alu_op(), rs, rt, rd, 8'(rand_bits(8)), 1'b0);
            prev2 = prev1;
            prev1 = rd;
        end
        for (int r = 0; r < REG_N; r++) wwd(reg_idx_t'(r));

        for (int i = 0; i < N_MEM; i++) begin
            rs   = rand_reg();
            imm  = 8'(rand_bits(8));
            addr = 8'(regs_model[rs]) + imm;
            issue_instr(SWD, rs, rand_reg(), 2'd0, imm, 1'b0);
            rs = rand_reg(); // Same address through another base
            rd = rand_reg();
            issue_instr(LWD, rs, 2'd0, rd, addr - 8'(regs_model[rs]), 1'b0);
            wwd(rd);
        end

        for (int i = 0; i < N_FLUSH; i++) begin
            kill = 1'(rand_bits(1));
            case (2'(rand_bits(2)))
                2'd2: begin
                    rs   = rand_reg();
                    addr = stored_q[rand_bits(8) % stored_q.size()]; // Aim at a stored word
                    issue_instr(SWD, rs, rand_reg(), 2'd0, addr - 8'(regs_model[rs]), kill);
                end
                2'd3: issue_instr(WWD, rand_reg(), 2'd0, 2'd0, 8'h00, kill);
                default: issue_instr(rand_alu_op(), rand_reg(), rand_reg(), rand_reg(),
                                     8'(rand_bits(8)), kill);
            endcase
        end
        for (int r = 0; r < REG_N; r++) wwd(reg_idx_t'(r));
        // Every stored word is read back
        foreach (stored_q[i]) begin
            rs = rand_reg();
            rd = rand_reg();
            issue_instr(LWD, rs, 2'd0, rd, stored_q[i] - 8'(regs_model[rs]), 1'b0);
            wwd(rd);
        end

        issue_instr(HLT, 2'd0, 2'd0, 2'd0, 8'h00, 1'b0);
        while (exp_q.size() > 0) idle_cycle();
        repeat (2) idle_cycle(); // done must drop again
        $display("Test passed");
        $finish;
    end

endmodule

//--- sources.f
common/backend_pkg.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/pipe_reg.sv
hw/data_mem.sv
hw/cpu_backend.sv
test/backend_props.sv
test/backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the result
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module backend_tb \
    -Mdir obj_dir -o backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
